// File: common/rv_pkg.sv
////////////////////////////////////////
// RV32I subset, 32-bit only. LOAD, STORE and SYSTEM decode but retire as no-ops
////////////////////////////////////////

package rv_pkg;

    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;
    localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

    // Major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_SYSTEM = 7'b1110011
    } opcode_t;

    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_N    // No immediate
    } inst_fmt_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // Branch funct3 encodings
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branch_fn_t;

    typedef struct packed {
        opcode_t                opcode;
        inst_fmt_t              fmt;
        logic [2:0]             funct3;
        logic [REG_ADDR_W-1:0]  rd;
        logic [REG_ADDR_W-1:0]  rs1;
        logic [REG_ADDR_W-1:0]  rs2;
        logic [XLEN-1:0]        imm;
        alu_op_t                alu_op;
        logic                   rd_we;    // Never set for rd == x0
    } decoded_t;

    typedef struct packed {
        logic [XLEN-1:0]        pc;
        logic [31:0]            inst;
        logic                   we;
        logic [REG_ADDR_W-1:0]  rd;
        logic [XLEN-1:0]        wdata;
    } retire_t;

endpackage

// File: source/rv_decoder.sv
////////////////////////////////////////
// Pure combinational decode
////////////////////////////////////////
`timescale 1ns/1ps

module rv_decoder (
    input  logic [31:0]      inst,
    output rv_pkg::decoded_t dec
);

    rv_pkg::opcode_t            opcode;
    rv_pkg::inst_fmt_t          fmt;
    rv_pkg::alu_op_t            alu_op;
    logic [6:0]                 funct7;
    logic [2:0]                 funct3;
    logic [rv_pkg::XLEN-1:0]    imm;
    logic                       writes_rd;

    // Unknown opcodes keep their raw value and fall to the defaults below
    assign opcode = rv_pkg::opcode_t'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        case (opcode)
            rv_pkg::OP_REG:                     fmt = rv_pkg::FMT_R;
            rv_pkg::OP_IMM, rv_pkg::OP_LOAD,
            rv_pkg::OP_JALR, rv_pkg::OP_SYSTEM: fmt = rv_pkg::FMT_I;
            rv_pkg::OP_STORE:                   fmt = rv_pkg::FMT_S;
            rv_pkg::OP_BRANCH:                  fmt = rv_pkg::FMT_B;
            rv_pkg::OP_LUI, rv_pkg::OP_AUIPC:   fmt = rv_pkg::FMT_U;
            rv_pkg::OP_JAL:                     fmt = rv_pkg::FMT_J;
            default:                            fmt = rv_pkg::FMT_N;
        endcase
    end

    always_comb begin
        case (fmt)
            rv_pkg::FMT_I: imm = {{20{inst[31]}}, inst[31:20]};
            rv_pkg::FMT_S: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            rv_pkg::FMT_B: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            rv_pkg::FMT_U: imm = {inst[31:12], 12'b0};
            rv_pkg::FMT_J: imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default:       imm = '0;
        endcase
    end

    always_comb begin
        alu_op = rv_pkg::ALU_ADD;    // Also address/offset adds
        if (opcode == rv_pkg::OP_REG || opcode == rv_pkg::OP_IMM) begin
            case (funct3)
                3'b000: alu_op = (fmt == rv_pkg::FMT_R && funct7[5]) ? rv_pkg::ALU_SUB
                                                                      : rv_pkg::ALU_ADD;
                3'b001: alu_op = rv_pkg::ALU_SLL;
                3'b010: alu_op = rv_pkg::ALU_SLT;
                3'b011: alu_op = rv_pkg::ALU_SLTU;
                3'b100: alu_op = rv_pkg::ALU_XOR;
                3'b101: alu_op = funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                3'b110: alu_op = rv_pkg::ALU_OR;
                default: alu_op = rv_pkg::ALU_AND;
            endcase
        end
    end

    always_comb begin
        case (opcode)
            rv_pkg::OP_REG, rv_pkg::OP_IMM, rv_pkg::OP_LUI,
            rv_pkg::OP_AUIPC, rv_pkg::OP_JAL, rv_pkg::OP_JALR: writes_rd = 1'b1;
            default:                                           writes_rd = 1'b0;
        endcase
    end

    always_comb begin
        dec.opcode = opcode;
        dec.fmt    = fmt;
        dec.funct3 = funct3;
        dec.rd     = inst[11:7];
        dec.rs1    = inst[19:15];
        dec.rs2    = inst[24:20];
        dec.imm    = imm;
        dec.alu_op = alu_op;
        dec.rd_we  = writes_rd && (inst[11:7] != '0);
    end

endmodule

// File: source/rv_regfile.sv
////////////////////////////////////////
// Reads are combinational, x0 reads zero
////////////////////////////////////////
`timescale 1ns/1ps

module rv_regfile (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [rv_pkg::REG_ADDR_W-1:0] raddr1,
    input  logic [rv_pkg::REG_ADDR_W-1:0] raddr2,
    output logic [rv_pkg::XLEN-1:0]       rdata1,
    output logic [rv_pkg::XLEN-1:0]       rdata2,
    input  logic                          we,
    input  logic [rv_pkg::REG_ADDR_W-1:0] waddr,
    input  logic [rv_pkg::XLEN-1:0]       wdata
);

    logic [rv_pkg::XLEN-1:0] regs [2**rv_pkg::REG_ADDR_W];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**rv_pkg::REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: execute/rv_alu.sv
////////////////////////////////////////
// Combinational, shifts use the low 5 bits of B
////////////////////////////////////////
`timescale 1ns/1ps

module rv_alu (
    input  rv_pkg::decoded_t          dec,
    input  logic [rv_pkg::XLEN-1:0]   pc,
    input  logic [rv_pkg::XLEN-1:0]   rs1_data,
    input  logic [rv_pkg::XLEN-1:0]   rs2_data,
    output logic [rv_pkg::XLEN-1:0]   alu_result
);

    logic [rv_pkg::XLEN-1:0] op_a;
    logic [rv_pkg::XLEN-1:0] op_b;
    logic [4:0]              shamt;
    logic                    lt_signed;
    logic                    lt_unsigned;

    always_comb begin
        case (dec.opcode)
            rv_pkg::OP_LUI:    op_a = '0;
            rv_pkg::OP_AUIPC,
            rv_pkg::OP_JAL,
            rv_pkg::OP_BRANCH: op_a = pc;
            default:           op_a = rs1_data;
        endcase
    end

    assign op_b  = (dec.fmt == rv_pkg::FMT_R) ? rs2_data : dec.imm;
    assign shamt = op_b[4:0];

    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    always_comb begin
        case (dec.alu_op)
            rv_pkg::ALU_ADD:  alu_result = op_a + op_b;
            rv_pkg::ALU_SUB:  alu_result = op_a - op_b;
            rv_pkg::ALU_SLL:  alu_result = op_a << shamt;
            rv_pkg::ALU_SLT:  alu_result = {{(rv_pkg::XLEN-1){1'b0}}, lt_signed};
            rv_pkg::ALU_SLTU: alu_result = {{(rv_pkg::XLEN-1){1'b0}}, lt_unsigned};
            rv_pkg::ALU_XOR:  alu_result = op_a ^ op_b;
            rv_pkg::ALU_SRL:  alu_result = op_a >> shamt;
            rv_pkg::ALU_SRA:  alu_result = $unsigned($signed(op_a) >>> shamt);
            rv_pkg::ALU_OR:   alu_result = op_a | op_b;
            rv_pkg::ALU_AND:  alu_result = op_a & op_b;
            default:          alu_result = op_a + op_b;
        endcase
    end

endmodule

// File: execute/rv_branch.sv
////////////////////////////////////////
// Jump target has its own adder, runs beside the ALU
////////////////////////////////////////
`timescale 1ns/1ps

module rv_branch (
    input  rv_pkg::decoded_t          dec,
    input  logic [rv_pkg::XLEN-1:0]   pc,
    input  logic [rv_pkg::XLEN-1:0]   rs1_data,
    input  logic [rv_pkg::XLEN-1:0]   rs2_data,
    output logic                      jump_taken,
    output logic [rv_pkg::XLEN-1:0]   jump_target
);

    rv_pkg::branch_fn_t      fn;
    logic                    cond;
    logic [rv_pkg::XLEN-1:0] base;
    logic [rv_pkg::XLEN-1:0] sum;

    assign fn = rv_pkg::branch_fn_t'(dec.funct3);

    always_comb begin
        case (fn)
            rv_pkg::BR_EQ:  cond = rs1_data == rs2_data;
            rv_pkg::BR_NE:  cond = rs1_data != rs2_data;
            rv_pkg::BR_LT:  cond = $signed(rs1_data) < $signed(rs2_data);
            rv_pkg::BR_GE:  cond = $signed(rs1_data) >= $signed(rs2_data);
            rv_pkg::BR_LTU: cond = rs1_data < rs2_data;
            rv_pkg::BR_GEU: cond = rs1_data >= rs2_data;
            default:        cond = 1'b0;    // funct3 010/011 never branch
        endcase
    end

    assign base = (dec.opcode == rv_pkg::OP_JALR) ? rs1_data : pc;
    assign sum  = base + dec.imm;

    always_comb begin
        jump_target = sum;
        case (dec.opcode)
            rv_pkg::OP_JAL:    jump_taken = 1'b1;
            rv_pkg::OP_BRANCH: jump_taken = cond;
            rv_pkg::OP_JALR: begin
                jump_taken  = 1'b1;
                jump_target = {sum[rv_pkg::XLEN-1:1], 1'b0};
            end
            default:           jump_taken = 1'b0;
        endcase
    end

endmodule

// File: source/rv_core_ctrl.sv
////////////////////////////////////////
// One instruction in flight, EXEC is always a single cycle
////////////////////////////////////////
`timescale 1ns/1ps

module rv_core_ctrl (
    input  logic                          clk,
    input  logic                          reset,
    output logic                          imem_req,
    output logic [rv_pkg::XLEN-1:0]       imem_addr,
    input  logic                          imem_valid,
    input  logic [31:0]                   imem_rdata,
    output logic [31:0]                   inst,
    output logic [rv_pkg::XLEN-1:0]       pc,
    input  rv_pkg::decoded_t              dec,
    input  logic [rv_pkg::XLEN-1:0]       alu_result,
    input  logic                          jump_taken,
    input  logic [rv_pkg::XLEN-1:0]       jump_target,
    output logic                          reg_we,
    output logic [rv_pkg::REG_ADDR_W-1:0] reg_waddr,
    output logic [rv_pkg::XLEN-1:0]       reg_wdata,
    output logic                          retire_valid,
    output rv_pkg::retire_t               retire
);

    typedef enum logic {
        FETCH,
        EXEC
    } state_t;

    state_t                  state;
    logic                    req_q;
    logic                    accept;
    logic [rv_pkg::XLEN-1:0] pc_q;
    logic [rv_pkg::XLEN-1:0] pc_plus4;
    logic [rv_pkg::XLEN-1:0] next_pc;
    logic [rv_pkg::XLEN-1:0] wb_data;
    logic [31:0]             inst_q;

    assign accept = (state == FETCH) && req_q && imem_valid;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= FETCH;
            req_q <= 1'b0;
            pc_q  <= rv_pkg::RESET_PC;
        end else begin
            case (state)
                FETCH: begin
                    if (accept) begin
                        state <= EXEC;
                        req_q <= 1'b0;
                    end else begin
                        req_q <= 1'b1;    // First rise after reset
                    end
                end
                EXEC: begin
                    state <= FETCH;
                    req_q <= 1'b1;        // Next request together with the new PC
                    pc_q  <= next_pc;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            inst_q <= imem_rdata;
        end
    end

    assign pc_plus4 = pc_q + rv_pkg::XLEN'(4);
    assign next_pc  = jump_taken ? jump_target : pc_plus4;

    // Link value for jumps
    assign wb_data = (dec.opcode == rv_pkg::OP_JAL || dec.opcode == rv_pkg::OP_JALR)
                     ? pc_plus4 : alu_result;

    assign imem_req     = req_q;
    assign imem_addr    = pc_q;
    assign inst         = inst_q;
    assign pc           = pc_q;
    assign retire_valid = (state == EXEC);

    assign reg_we    = (state == EXEC) && dec.rd_we;
    assign reg_waddr = dec.rd;
    assign reg_wdata = wb_data;

    always_comb begin
        retire.pc    = pc_q;
        retire.inst  = inst_q;
        retire.we    = dec.rd_we;
        retire.rd    = dec.rd;
        retire.wdata = wb_data;
    end

endmodule

// File: source/rv_core.sv
////////////////////////////////////////
// Top level, imem answers only while imem_req is high
////////////////////////////////////////
`timescale 1ns/1ps

module rv_core (
    input  logic                    clk,
    input  logic                    reset,
    output logic                    imem_req,
    output logic [rv_pkg::XLEN-1:0] imem_addr,
    input  logic                    imem_valid,
    input  logic [31:0]             imem_rdata,
    output logic                    retire_valid,
    output rv_pkg::retire_t         retire
);

    logic [31:0]                   inst;
    logic [rv_pkg::XLEN-1:0]       pc;
    rv_pkg::decoded_t              dec;
    logic [rv_pkg::XLEN-1:0]       rs1_data;
    logic [rv_pkg::XLEN-1:0]       rs2_data;
    logic [rv_pkg::XLEN-1:0]       alu_result;
    logic                          jump_taken;
    logic [rv_pkg::XLEN-1:0]       jump_target;
    logic                          reg_we;
    logic [rv_pkg::REG_ADDR_W-1:0] reg_waddr;
    logic [rv_pkg::XLEN-1:0]       reg_wdata;

    rv_core_ctrl u_ctrl (
        .clk(clk), .reset(reset),
        .imem_req(imem_req), .imem_addr(imem_addr),
        .imem_valid(imem_valid), .imem_rdata(imem_rdata),
        .inst(inst), .pc(pc), .dec(dec),
        .alu_result(alu_result), .jump_taken(jump_taken), .jump_target(jump_target),
        .reg_we(reg_we), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
        .retire_valid(retire_valid), .retire(retire)
    );

    rv_decoder u_decoder (.inst(inst), .dec(dec));

    rv_regfile u_regfile (
        .clk(clk), .reset(reset),
        .raddr1(dec.rs1), .raddr2(dec.rs2),
        .rdata1(rs1_data), .rdata2(rs2_data),
        .we(reg_we), .waddr(reg_waddr), .wdata(reg_wdata)
    );

    rv_alu u_alu (
        .dec(dec), .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .alu_result(alu_result)
    );

    rv_branch u_branch (
        .dec(dec), .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .jump_taken(jump_taken), .jump_target(jump_target)
    );

endmodule

// File: bench/tb_clock.sv
////////////////////////////////////////
// 10 ns clock, reset drops 1 ns after 4th edge
////////////////////////////////////////
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

// File: bench/rv_core_props.sv
////////////////////////////////////////
// Protocol checks on the rv_core ports
////////////////////////////////////////
`timescale 1ns/1ps

module rv_core_props (
    input logic        clk,
    input logic        reset,
    input logic        imem_req,
    input logic [31:0] imem_addr,
    input logic        imem_valid,
    input logic        retire_valid
);

    // Held until the memory answers
    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        imem_req && !imem_valid |=> imem_req && $stable(imem_addr))
        else $error("imem_req or imem_addr changed while waiting for imem_valid");

    a_retire_after_accept: assert property (@(posedge clk) disable iff (reset)
        imem_req && imem_valid |=> retire_valid && !imem_req)
        else $error("retire_valid did not follow the accepted fetch by one cycle");

    a_retire_needs_accept: assert property (@(posedge clk) disable iff (reset)
        retire_valid |-> $past(imem_req && imem_valid))
        else $error("retire_valid without an accepted fetch the cycle before");

    a_retire_pulse: assert property (@(posedge clk) disable iff (reset)
        retire_valid |=> !retire_valid)
        else $error("retire_valid held longer than one cycle");

    a_quiet_in_reset: assert property (@(posedge clk)
        reset |-> !imem_req && !retire_valid)
        else $error("imem_req or retire_valid high during reset");

    a_first_fetch: assert property (@(posedge clk)
        $fell(reset) |=> imem_req && imem_addr == rv_pkg::RESET_PC)
        else $error("first fetch after reset is not at the reset PC");

endmodule

bind rv_core rv_core_props u_props (.*);

// File: bench/rv_core_tb.sv
////////////////////////////////////////
// Fixed program on a memory that answers in 0 to 3 cycles
////////////////////////////////////////
`timescale 1ns/1ps

module rv_core_tb;

    localparam int PROG_LEN = 42;
    localparam int WATCHDOG_NS = (4 + PROG_LEN * 10) * 10;
    localparam logic [6:0] OPI = 7'h13;

    logic                  clk;
    logic                  reset;
    logic                  imem_req;
    logic [31:0]           imem_addr;
    logic                  imem_valid;
    logic [31:0]           imem_rdata;
    logic                  retire_valid;
    rv_pkg::retire_t       retire;

    logic [31:0] mem [PROG_LEN];
    logic [31:0] shadow [32];    // x0 never written
    logic [15:0] lfsr = 16'd7460;
    int          checks [6];
    int          errors [6];
    string       group_name [6] = '{"arithmetic", "upper immediates", "branches",
                                    "jumps", "dropped classes", "reset and timing"};

    tb_clock u_clock (.clk(clk), .reset(reset));

    rv_core DUT (
        .clk(clk), .reset(reset),
        .imem_req(imem_req), .imem_addr(imem_addr),
        .imem_valid(imem_valid), .imem_rdata(imem_rdata),
        .retire_valid(retire_valid), .retire(retire)
    );

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};    // x^16+x^14+x^13+x^11
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] off;
        int          idx;
        off = addr - rv_pkg::RESET_PC;
        idx = int'(off >> 2);
        if (off[1:0] != 2'b00 || off >= 32'(PROG_LEN * 4)) begin
            return 32'h0;    // Unknown opcode that retires as a no-op
        end
        return mem[idx];
    endfunction

    // RV32I integer rules where alt selects SUB or SRA
    function automatic logic [31:0] alu_calc(input logic [2:0] f3, input logic alt,
            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_cond(input logic [2:0] f3, input logic [31:0] a,
            input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            3'd7:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic predict(input logic [31:0] pc, input logic [31:0] ins, output logic we,
            output logic [31:0] wd, output logic [31:0] npc, output int grp);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [2:0]  f3;
        a = shadow[ins[19:15]];
        b = shadow[ins[24:20]];
        f3 = ins[14:12];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        we = 1'b0;
        wd = 32'h0;
        npc = pc + 32'd4;
        grp = 4;
        case (ins[6:0])
            7'h33: begin
                grp = 0;
                we = 1'b1;
                wd = alu_calc(f3, ins[30], a, b);
            end
            7'h13: begin
                grp = 0;
                we = 1'b1;
                wd = alu_calc(f3, f3 == 3'd5 && ins[30], a, imm_i);
            end
            7'h37, 7'h17: begin
                grp = 1;
                we = 1'b1;
                wd = {ins[31:12], 12'h0} + (ins[5] ? 32'h0 : pc);
            end
            7'h63: begin
                grp = 2;
                if (branch_cond(f3, a, b))
                    npc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            7'h6f, 7'h67: begin
                grp = 3;
                we = 1'b1;
                wd = pc + 32'd4;
                if (ins[3]) npc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                else        npc = (a + imm_i) & ~32'h1;
            end
            default: ;
        endcase
        if (ins[11:7] == 5'd0) we = 1'b0;
    endtask

    task automatic check(input logic ok, input int grp, input string what);
        checks[grp]++;
        assert (ok) else begin
            errors[grp]++;
            $display("Error at %0t ns: %s", $time, what);
        end
    endtask

    initial begin
        for (int i = 0; i < PROG_LEN; i++) mem[i] = i_type(12'(i), 5'd0, 3'd0, 5'd27, OPI);
        mem[0] = i_type(12'd5, 5'd0, 3'd0, 5'd1, OPI);
        mem[1] = i_type(12'hffd, 5'd0, 3'd0, 5'd2, OPI);
        for (int f = 0; f < 8; f++) begin
            mem[2 + f] = r_type(7'h00, 5'd1, 5'd2, 3'(f), 5'(3 + f));
            mem[12 + f] = i_type((f == 1) ? 12'd3 : (f == 5) ? 12'h404 : 12'hcf3,
                                 5'd2, 3'(f), 5'(13 + f), OPI);
        end
        mem[10] = r_type(7'h20, 5'd1, 5'd2, 3'd0, 5'd11);    // sub
        mem[11] = r_type(7'h20, 5'd1, 5'd2, 3'd5, 5'd12);    // sra
        mem[20] = i_type(12'd4, 5'd2, 3'd5, 5'd21, OPI);      // srli
        mem[21] = i_type(12'd7, 5'd1, 3'd0, 5'd0, OPI);       // x0 target
        mem[22] = {20'h12345, 5'd22, 7'h37};
        mem[23] = {20'hfffff, 5'd23, 7'h17};
        mem[24] = b_type(13'd8, 5'd1, 5'd1, 3'd0);            // taken
        mem[26] = b_type(13'd8, 5'd1, 5'd1, 3'd1);
        mem[27] = b_type(13'd8, 5'd1, 5'd2, 3'd4);            // taken
        mem[29] = b_type(13'd8, 5'd1, 5'd2, 3'd5);
        mem[30] = b_type(13'd8, 5'd1, 5'd2, 3'd6);
        mem[31] = b_type(13'd8, 5'd1, 5'd2, 3'd7);            // taken
        mem[33] = j_type(21'd8, 5'd24);
        mem[35] = {20'h0, 5'd25, 7'h17};
        mem[36] = i_type(12'd13, 5'd25, 3'd0, 5'd26, 7'h67);  // Odd target that lands on 38
        mem[38] = i_type(12'd0, 5'd1, 3'd2, 5'd28, 7'h03);    // lw
        mem[39] = 32'h0000_0073;
        mem[40] = 32'h0012_345b;
        mem[41] = j_type(21'd0, 5'd0);                        // Self-loop
    end

    initial begin
        logic [31:0] exp_pc;
        logic [31:0] exp_wd;
        logic [31:0] exp_npc;
        logic [31:0] ins;
        logic        exp_we;
        logic        done;
        int          grp;
        int          prev_grp;
        int          delay;
        int          total_checks;
        int          total_errors;
        imem_valid = 1'b0;
        imem_rdata = 32'h0;
        foreach (shadow[i]) shadow[i] = 32'h0;
        foreach (checks[i]) begin
            checks[i] = 0;
            errors[i] = 0;
        end
        exp_pc = rv_pkg::RESET_PC;
        prev_grp = 5;
        done = 1'b0;
        wait (!reset);
        while (1) begin
            @(posedge clk);
            #1;
            while (!imem_req) begin
                @(posedge clk);
                #1;
            end
            check(imem_addr == exp_pc, prev_grp,
                  $sformatf("fetch address %h, expected %h", imem_addr, exp_pc));
            if (done) break;
            delay = 0;
            repeat (2) begin
                delay = delay * 2 + int'(lfsr[0]);
                lfsr = lfsr_next(lfsr);
            end
            repeat (delay) begin
                @(posedge clk);
                #1;
            end
            ins = fetch_word(imem_addr);
            imem_valid = 1'b1;
            imem_rdata = ins;
            @(posedge clk);
            #1;
            imem_valid = 1'b0;
            predict(exp_pc, ins, exp_we, exp_wd, exp_npc, grp);
            check(retire_valid, 5, "retire_valid missing one cycle after the fetch");
            check(retire.pc == exp_pc && retire.inst == ins, grp,
                  $sformatf("retire pc %h inst %h, expected %h %h",
                            retire.pc, retire.inst, exp_pc, ins));
            check(retire.we == exp_we, grp,
                  $sformatf("write enable %b for inst %h, expected %b", retire.we, ins, exp_we));
            if (exp_we) begin
                check(retire.rd == ins[11:7] && retire.wdata == exp_wd, grp,
                      $sformatf("x%0d write data %h, expected x%0d %h",
                                retire.rd, retire.wdata, ins[11:7], exp_wd));
                shadow[ins[11:7]] = exp_wd;
            end
            done = (exp_npc == exp_pc);
            exp_pc = exp_npc;
            prev_grp = grp;
        end
        total_checks = 0;
        total_errors = 0;
        for (int g = 0; g < 6; g++) begin
            $display("%-18s %0d checks, %0d errors", group_name[g], checks[g], errors[g]);
            total_checks += checks[g];
            total_errors += errors[g];
        end
        $display("Total: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the program did not reach its final loop in time");
        $display("Test FAILED");
        $finish;
    end

endmodule

// File: rv_core.f
common/rv_pkg.sv
source/rv_decoder.sv
source/rv_regfile.sv
execute/rv_alu.sv
execute/rv_branch.sv
source/rv_core_ctrl.sv
source/rv_core.sv
bench/tb_clock.sv
bench/rv_core_props.sv
bench/rv_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module rv_core_tb -f rv_core.f -o rv_core_sim
out=$(./obj_dir/rv_core_sim)
echo "$out"

if echo "$out" | grep -q "^Test OK$"; then
    exit 0
else
    exit 1
fi
